// File: common/dma_bridge_pkg.sv
// dma bridge shared definitions: widths, control byte bits, request fields, FSM states
package dma_bridge_pkg;

  // ************************************************************************
  // widths
  // ************************************************************************
  localparam int data_w = 64;            // engine and stream data
  localparam int ctrl_w = 8;             // engine control byte
  localparam int keep_w = 8;             // axi stream tkeep
  localparam int len_w  = 16;            // length and byte count
  localparam int tag_w  = 4;
  localparam int req_w  = 128;           // request word 1 over request word 0

  // control byte bits
  localparam int ctrl_first_ack  = 0;
  localparam int ctrl_lo_valid   = 2;    // low half of data valid
  localparam int ctrl_hi_valid   = 3;    // high half valid, end marker on tohost
  localparam int ctrl_req        = 4;    // request / upstream ack / downstream end
  localparam int ctrl_second_ack = 5;

  // request and acknowledge field positions
  localparam int req_tag_lsb   = 36;     // word 0, bits 39..36
  localparam int req_len_lsb   = 0;      // word 0, bits 15..0
  localparam int req_bytes_lsb = 48;     // word 1, bits 63..48
  localparam int ack_tag_lsb   = 4;      // first ack, bits 7..4

  // ************************************************************************
  // FSM states
  // ************************************************************************
  typedef enum logic [1:0] {
    down_idle,
    down_ack,
    down_data
  } down_state_t;

  typedef enum logic [1:0] {
    up_req1,
    up_req2,
    up_data,
    up_ack
  } up_state_t;

endpackage

// File: hw/dma_ack_gen.sv
// acknowledge generator: tag word then length word, each held until the engine accepts it
module dma_ack_gen #(
  parameter bit up_dir = 1'b0
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  input  logic [dma_bridge_pkg::tag_w-1:0]    tag,
  input  logic [dma_bridge_pkg::len_w-1:0]    length,
  output logic [dma_bridge_pkg::data_w-1:0]   ack_data,
  output logic [dma_bridge_pkg::ctrl_w-1:0]   ack_ctrl,
  output logic                                ack_valid,
  input  logic                                accept,
  output logic                                done
);

  logic                              second;   // second word on the bus
  logic [dma_bridge_pkg::len_w-1:0]  len_q;
  logic [dma_bridge_pkg::ctrl_w-1:0] first_ctrl;
  logic [dma_bridge_pkg::ctrl_w-1:0] second_ctrl;
  logic [dma_bridge_pkg::data_w-1:0] first_word;
  logic [dma_bridge_pkg::data_w-1:0] second_word;

  always_comb
  begin
    first_ctrl = '0;
    first_ctrl[dma_bridge_pkg::ctrl_first_ack] = 1'b1;
    first_ctrl[dma_bridge_pkg::ctrl_req] = up_dir;     // upstream acks carry req
    second_ctrl = '0;
    second_ctrl[dma_bridge_pkg::ctrl_second_ack] = 1'b1;
    second_ctrl[dma_bridge_pkg::ctrl_req] = up_dir;
    first_word = '0;
    first_word[dma_bridge_pkg::ack_tag_lsb +: dma_bridge_pkg::tag_w] = tag;
    second_word = '0;
    second_word[dma_bridge_pkg::len_w-1:0] = len_q;
  end

  always_ff @(posedge clk)
  begin
    if (start)
      len_q <= length;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_valid <= 1'b0;
      second    <= 1'b0;
      ack_ctrl  <= '0;
      ack_data  <= '0;
    end
    else if (start)
    begin
      ack_valid <= 1'b1;
      second    <= 1'b0;
      ack_ctrl  <= first_ctrl;
      ack_data  <= first_word;
    end
    else if (ack_valid && accept)
    begin
      if (!second)
      begin
        second   <= 1'b1;            // tag taken, move to length
        ack_ctrl <= second_ctrl;
        ack_data <= second_word;
      end
      else
      begin
        ack_valid <= 1'b0;
        second    <= 1'b0;
        ack_ctrl  <= '0;
        ack_data  <= '0;
      end
    end
  end

  assign done = ack_valid & accept & second;

endmodule

// File: hw/downstream/req_fifo.sv
// request FIFO: register array with read and write pointers and an occupancy count
module req_fifo #(
  parameter int depth = 16,
  parameter int width = 128
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push,
  input  logic [width-1:0]                push_data,
  input  logic                            pop,
  output logic [width-1:0]                pop_data,
  output logic                            empty,
  output logic [$clog2(depth+1)-1:0]      count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == cnt_w'(depth));
  assign do_pop  = pop & ~empty;
  assign do_push = push & (~full | do_pop);   // a pop frees the slot this cycle

  assign pop_data = mem[rd_ptr];              // head entry

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: hw/downstream/down_channel.sv
// downstream channel: queue engine requests, acknowledge them, then feed the s1 stream back
module down_channel #(
  parameter int req_depth = 16
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [dma_bridge_pkg::data_w-1:0]   tohost_data,
  input  logic [dma_bridge_pkg::ctrl_w-1:0]   tohost_ctrl,
  input  logic                                tohost_valid,
  output logic                                tohost_almost_full,
  output logic [dma_bridge_pkg::data_w-1:0]   fromhost_data,
  output logic [dma_bridge_pkg::ctrl_w-1:0]   fromhost_ctrl,
  output logic                                fromhost_valid,
  input  logic                                fromhost_accept,
  input  logic                                s_tvalid,
  input  logic [dma_bridge_pkg::data_w-1:0]   s_tdata,
  input  logic [dma_bridge_pkg::keep_w-1:0]   s_tkeep,
  input  logic                                s_tlast,
  output logic                                s_tready
);

  localparam int cnt_w = $clog2(req_depth + 1);
  localparam logic [cnt_w-1:0] af_level = cnt_w'(req_depth - 1);

  dma_bridge_pkg::down_state_t       state;
  logic [dma_bridge_pkg::data_w-1:0] req_lo;       // request word 0
  logic                              req_word0;
  logic                              req_word1;
  logic                              pop;
  logic                              fifo_empty;
  logic [dma_bridge_pkg::req_w-1:0]  pop_data;
  logic [cnt_w-1:0]                  fifo_count;
  logic [dma_bridge_pkg::data_w-1:0] ack_data;
  logic [dma_bridge_pkg::ctrl_w-1:0] ack_ctrl;
  logic                              ack_valid;
  logic                              ack_done;
  logic                              in_data;
  logic [dma_bridge_pkg::ctrl_w-1:0] beat_ctrl;

  // ************************************************************************
  // request capture
  // ************************************************************************
  assign req_word0 = tohost_valid & tohost_ctrl[dma_bridge_pkg::ctrl_req]
                   & ~tohost_ctrl[dma_bridge_pkg::ctrl_hi_valid];
  assign req_word1 = tohost_valid & tohost_ctrl[dma_bridge_pkg::ctrl_req]
                   & tohost_ctrl[dma_bridge_pkg::ctrl_hi_valid];

  always_ff @(posedge clk)
  begin
    if (req_word0)
      req_lo <= tohost_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tohost_almost_full <= 1'b0;
    else
      tohost_almost_full <= (fifo_count >= af_level);   // lags count by a cycle
  end

  req_fifo #(
    .depth     (req_depth),
    .width     (dma_bridge_pkg::req_w)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (req_word1),                 // push on the high word
    .push_data ({tohost_data, req_lo}),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (fifo_empty),
    .count     (fifo_count)
  );

  // ************************************************************************
  // sequencer
  // ************************************************************************
  assign pop = (state == dma_bridge_pkg::down_idle) & ~fifo_empty;

  dma_ack_gen #(
    .up_dir    (1'b0)
  ) u_ack (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (pop),
    .tag       (pop_data[dma_bridge_pkg::req_tag_lsb +: dma_bridge_pkg::tag_w]),
    .length    (pop_data[dma_bridge_pkg::req_len_lsb +: dma_bridge_pkg::len_w]),
    .ack_data  (ack_data),
    .ack_ctrl  (ack_ctrl),
    .ack_valid (ack_valid),
    .accept    (fromhost_accept),
    .done      (ack_done)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= dma_bridge_pkg::down_idle;
    else
    begin
      case (state)
        dma_bridge_pkg::down_idle:
          if (pop)
            state <= dma_bridge_pkg::down_ack;
        dma_bridge_pkg::down_ack:
          if (ack_done)
            state <= dma_bridge_pkg::down_data;
        dma_bridge_pkg::down_data:
          if (s_tvalid && s_tready && s_tlast)
            state <= dma_bridge_pkg::down_idle;
        default:
          state <= dma_bridge_pkg::down_idle;
      endcase
    end
  end

  // data phase, stream straight onto the engine
  always_comb
  begin
    beat_ctrl = '0;
    beat_ctrl[dma_bridge_pkg::ctrl_lo_valid] = 1'b1;
    if (s_tlast)
    begin
      beat_ctrl[dma_bridge_pkg::ctrl_req] = 1'b1;      // end code
      beat_ctrl[dma_bridge_pkg::ctrl_hi_valid] = (s_tkeep > 8'h0f);
    end
    else
      beat_ctrl[dma_bridge_pkg::ctrl_hi_valid] = 1'b1;
  end

  assign in_data        = (state == dma_bridge_pkg::down_data);
  assign fromhost_data  = in_data ? s_tdata : ack_data;
  assign fromhost_valid = in_data ? s_tvalid : ack_valid;
  assign fromhost_ctrl  = in_data ? beat_ctrl : ack_ctrl;
  assign s_tready       = in_data & fromhost_accept;

endmodule

// File: hw/upstream/up_channel.sv
// upstream channel: parse engine request, pass data to m0 with tlast/tkeep, then acknowledge
module up_channel (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [dma_bridge_pkg::data_w-1:0]   tohost_data,
  input  logic [dma_bridge_pkg::ctrl_w-1:0]   tohost_ctrl,
  input  logic                                tohost_valid,
  output logic                                tohost_almost_full,
  output logic [dma_bridge_pkg::data_w-1:0]   fromhost_data,
  output logic [dma_bridge_pkg::ctrl_w-1:0]   fromhost_ctrl,
  output logic                                fromhost_valid,
  input  logic                                fromhost_accept,
  output logic                                m_tvalid,
  output logic [dma_bridge_pkg::data_w-1:0]   m_tdata,
  output logic [dma_bridge_pkg::keep_w-1:0]   m_tkeep,
  output logic                                m_tlast,
  input  logic                                m_tready
);

  dma_bridge_pkg::up_state_t         state;
  logic [dma_bridge_pkg::tag_w-1:0]  tag_q;
  logic [dma_bridge_pkg::len_w-1:0]  len_q;
  logic [dma_bridge_pkg::len_w-1:0]  bytes_q;      // byte count from word 1
  logic [dma_bridge_pkg::keep_w-1:0] keep_last;
  logic                              req_word;
  logic                              in_data;
  logic                              last_hs;
  logic                              ack_done;

  // both request words have the word-0 pattern, taken without m0 tready
  assign req_word = tohost_valid & tohost_ctrl[dma_bridge_pkg::ctrl_req]
                  & ~tohost_ctrl[dma_bridge_pkg::ctrl_hi_valid];

  assign in_data = (state == dma_bridge_pkg::up_data);
  assign last_hs = in_data & tohost_valid & m_tready
                 & tohost_ctrl[dma_bridge_pkg::ctrl_hi_valid];

  always_ff @(posedge clk)
  begin
    if (state == dma_bridge_pkg::up_req1 && req_word)
    begin
      tag_q <= tohost_data[dma_bridge_pkg::req_tag_lsb +: dma_bridge_pkg::tag_w];
      len_q <= tohost_data[dma_bridge_pkg::req_len_lsb +: dma_bridge_pkg::len_w];
    end
    if (state == dma_bridge_pkg::up_req2 && req_word)
      bytes_q <= tohost_data[dma_bridge_pkg::req_bytes_lsb +: dma_bridge_pkg::len_w];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= dma_bridge_pkg::up_req1;
    else
    begin
      case (state)
        dma_bridge_pkg::up_req1: if (req_word) state <= dma_bridge_pkg::up_req2;
        dma_bridge_pkg::up_req2: if (req_word) state <= dma_bridge_pkg::up_data;
        dma_bridge_pkg::up_data: if (last_hs)  state <= dma_bridge_pkg::up_ack;
        dma_bridge_pkg::up_ack:  if (ack_done) state <= dma_bridge_pkg::up_req1;
        default:                 state <= dma_bridge_pkg::up_req1;
      endcase
    end
  end

  // ************************************************************************
  // stream side
  // ************************************************************************
  always_comb
  begin
    for (int i = 0; i < dma_bridge_pkg::keep_w; i++)
      keep_last[i] = (bytes_q[2:0] == 3'd0) || (i < int'(bytes_q[2:0]));
  end

  assign m_tvalid           = in_data & tohost_valid;
  assign m_tdata            = in_data ? tohost_data : '0;
  assign m_tlast            = in_data & tohost_ctrl[dma_bridge_pkg::ctrl_hi_valid];
  assign m_tkeep            = m_tlast ? keep_last : '1;    // partial word only at the end
  assign tohost_almost_full = in_data & ~m_tready;

  dma_ack_gen #(
    .up_dir    (1'b1)
  ) u_ack (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (last_hs),
    .tag       (tag_q),
    .length    (len_q),
    .ack_data  (fromhost_data),
    .ack_ctrl  (fromhost_ctrl),
    .ack_valid (fromhost_valid),
    .accept    (fromhost_accept),
    .done      (ack_done)
  );

endmodule

// File: hw/dma_bridge_top.sv
// dma bridge top: engine channel 1 to s1 stream fifo, engine channel 0 to m0 stream fifo
module dma_bridge_top #(
  parameter int req_depth = 16
) (
  input  logic                                clk,
  input  logic                                rst_n,

  // channel 1, downstream
  input  logic [dma_bridge_pkg::data_w-1:0]   dma1_tohost_data,
  input  logic [dma_bridge_pkg::ctrl_w-1:0]   dma1_tohost_ctrl,
  input  logic                                dma1_tohost_valid,
  output logic                                dma1_tohost_almost_full,
  output logic [dma_bridge_pkg::data_w-1:0]   dma1_fromhost_data,
  output logic [dma_bridge_pkg::ctrl_w-1:0]   dma1_fromhost_ctrl,
  output logic                                dma1_fromhost_valid,
  input  logic                                dma1_fromhost_accept,
  input  logic                                s1_axis_fromhost_tvalid,
  output logic                                s1_axis_fromhost_tready,
  input  logic [dma_bridge_pkg::data_w-1:0]   s1_axis_fromhost_tdata,
  input  logic [dma_bridge_pkg::keep_w-1:0]   s1_axis_fromhost_tkeep,
  input  logic                                s1_axis_fromhost_tlast,

  // channel 0, upstream
  input  logic [dma_bridge_pkg::data_w-1:0]   dma0_tohost_data,
  input  logic [dma_bridge_pkg::ctrl_w-1:0]   dma0_tohost_ctrl,
  input  logic                                dma0_tohost_valid,
  output logic                                dma0_tohost_almost_full,
  output logic [dma_bridge_pkg::data_w-1:0]   dma0_fromhost_data,
  output logic [dma_bridge_pkg::ctrl_w-1:0]   dma0_fromhost_ctrl,
  output logic                                dma0_fromhost_valid,
  input  logic                                dma0_fromhost_accept,
  output logic                                m0_axis_tohost_tvalid,
  input  logic                                m0_axis_tohost_tready,
  output logic [dma_bridge_pkg::data_w-1:0]   m0_axis_tohost_tdata,
  output logic [dma_bridge_pkg::keep_w-1:0]   m0_axis_tohost_tkeep,
  output logic                                m0_axis_tohost_tlast
);

  // the two channels are independent, no shared resource
  down_channel #(
    .req_depth          (req_depth)
  ) u_down (
    .clk                (clk),
    .rst_n              (rst_n),
    .tohost_data        (dma1_tohost_data),
    .tohost_ctrl        (dma1_tohost_ctrl),
    .tohost_valid       (dma1_tohost_valid),
    .tohost_almost_full (dma1_tohost_almost_full),
    .fromhost_data      (dma1_fromhost_data),
    .fromhost_ctrl      (dma1_fromhost_ctrl),
    .fromhost_valid     (dma1_fromhost_valid),
    .fromhost_accept    (dma1_fromhost_accept),
    .s_tvalid           (s1_axis_fromhost_tvalid),
    .s_tdata            (s1_axis_fromhost_tdata),
    .s_tkeep            (s1_axis_fromhost_tkeep),
    .s_tlast            (s1_axis_fromhost_tlast),
    .s_tready           (s1_axis_fromhost_tready)
  );

  up_channel u_up (
    .clk                (clk),
    .rst_n              (rst_n),
    .tohost_data        (dma0_tohost_data),
    .tohost_ctrl        (dma0_tohost_ctrl),
    .tohost_valid       (dma0_tohost_valid),
    .tohost_almost_full (dma0_tohost_almost_full),
    .fromhost_data      (dma0_fromhost_data),
    .fromhost_ctrl      (dma0_fromhost_ctrl),
    .fromhost_valid     (dma0_fromhost_valid),
    .fromhost_accept    (dma0_fromhost_accept),
    .m_tvalid           (m0_axis_tohost_tvalid),
    .m_tdata            (m0_axis_tohost_tdata),
    .m_tkeep            (m0_axis_tohost_tkeep),
    .m_tlast            (m0_axis_tohost_tlast),
    .m_tready           (m0_axis_tohost_tready)
  );

endmodule

// File: sim/tb_clk_gen.sv
// testbench clock source, free running with an 8 ns period
module tb_clk_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 4;

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;   // 8 ns period
  end

endmodule

// File: sim/dma_bridge_chk.sv
// protocol checker for the dma bridge top: ack hold, upstream valid, downstream ready
module dma_bridge_chk (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              dma1_fromhost_valid,
  input logic [dma_bridge_pkg::data_w-1:0] dma1_fromhost_data,
  input logic [dma_bridge_pkg::ctrl_w-1:0] dma1_fromhost_ctrl,
  input logic                              dma1_fromhost_accept,
  input logic                              s1_axis_fromhost_tready,
  input logic                              m0_axis_tohost_tvalid,
  input logic                              dma0_tohost_valid,
  input logic                              dma0_fromhost_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  // ack words never carry lo_valid, data beats always do
  ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dma1_fromhost_valid && !dma1_fromhost_accept
      && !dma1_fromhost_ctrl[dma_bridge_pkg::ctrl_lo_valid]
    |=> dma1_fromhost_valid && $stable(dma1_fromhost_data) && $stable(dma1_fromhost_ctrl))
  else
  begin
    assert_fails++;
    $error("downstream ack word changed before accept");
  end

  // data beats and ack words never share a cycle upstream
  up_valid: assert property (@(posedge clk) disable iff (!rst_n)
    m0_axis_tohost_tvalid |-> dma0_tohost_valid && !dma0_fromhost_valid)
  else
  begin
    assert_fails++;
    $error("m0 tvalid high without engine valid or during an ack word");
  end

  down_ready: assert property (@(posedge clk) disable iff (!rst_n)
    s1_axis_fromhost_tready |-> dma1_fromhost_valid)
  else
  begin
    assert_fails++;
    $error("s1 tready high while engine valid is low");
  end

endmodule

// attach to every dma bridge top
bind dma_bridge_top dma_bridge_chk u_chk (.*);

// File: sim/dma_bridge_tb.sv
// dma bridge testbench: replays transfer cases on both channels and checks both sides
module dma_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int req_depth = 16;
  localparam int max_cases = 32;
  localparam logic [7:0] c_first  = 8'h1 << dma_bridge_pkg::ctrl_first_ack;
  localparam logic [7:0] c_lo     = 8'h1 << dma_bridge_pkg::ctrl_lo_valid;
  localparam logic [7:0] c_hi     = 8'h1 << dma_bridge_pkg::ctrl_hi_valid;
  localparam logic [7:0] c_req    = 8'h1 << dma_bridge_pkg::ctrl_req;
  localparam logic [7:0] c_second = 8'h1 << dma_bridge_pkg::ctrl_second_ack;

  logic        clk;
  logic        rst_n;
  logic [63:0] dma1_tohost_data;
  logic [7:0]  dma1_tohost_ctrl;
  logic        dma1_tohost_valid;
  logic        dma1_tohost_almost_full;
  logic [63:0] dma1_fromhost_data;
  logic [7:0]  dma1_fromhost_ctrl;
  logic        dma1_fromhost_valid;
  logic        dma1_fromhost_accept;
  logic        s1_axis_fromhost_tvalid;
  logic        s1_axis_fromhost_tready;
  logic [63:0] s1_axis_fromhost_tdata;
  logic [7:0]  s1_axis_fromhost_tkeep;
  logic        s1_axis_fromhost_tlast;
  logic [63:0] dma0_tohost_data;
  logic [7:0]  dma0_tohost_ctrl;
  logic        dma0_tohost_valid;
  logic        dma0_tohost_almost_full;
  logic [63:0] dma0_fromhost_data;
  logic [7:0]  dma0_fromhost_ctrl;
  logic        dma0_fromhost_valid;
  logic        dma0_fromhost_accept;
  logic        m0_axis_tohost_tvalid;
  logic        m0_axis_tohost_tready;
  logic [63:0] m0_axis_tohost_tdata;
  logic [7:0]  m0_axis_tohost_tkeep;
  logic        m0_axis_tohost_tlast;

  // transfer cases from the data file
  byte         case_chan  [max_cases];
  logic [3:0]  case_tag   [max_cases];
  logic [15:0] case_len   [max_cases];
  logic [15:0] case_bytes [max_cases];
  int          case_beats [max_cases];
  logic [7:0]  case_keep  [max_cases];
  int          case_stall [max_cases];
  int          n_cases;
  integer      seed;
  int          cycles = 0;
  int          limit = 0;      // zero until the cases are known

  tb_clk_gen u_clk (.clk(clk));

  dma_bridge_top #(.req_depth(req_depth)) DUT (.*);

  task automatic check_value(input logic [63:0] observed, input logic [63:0] expected,
                             input string name);
    if (observed !== expected)
    begin
      $display("Fail at %0t ns: %s observed %h expected %h", $time, name, observed, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // ready or accept, high three times in four when stalls are on
  function automatic logic pick_ready(input int stall);
    if (stall == 0)
      return 1'b1;
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic read_cases();
    int    fd;
    int    code;
    string line;
    byte   chan;
    int    tag, len, bytes, beats, keep, stall;
    fd = $fopen("sim/dma_bridge_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the cases file sim/dma_bridge_cases.txt");
      $display("sim failed");
      $fatal(1, "no cases file");
    end
    n_cases = 0;
    while (!$feof(fd) && n_cases < max_cases)
    begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#")
      begin
        code = $sscanf(line, "%c %h %h %h %d %h %d", chan, tag, len, bytes, beats, keep, stall);
        if (code == 7)
        begin
          case_chan[n_cases]  = chan;
          case_tag[n_cases]   = 4'(tag);
          case_len[n_cases]   = 16'(len);
          case_bytes[n_cases] = 16'(bytes);
          case_beats[n_cases] = beats;
          case_keep[n_cases]  = 8'(keep);
          case_stall[n_cases] = stall;
          n_cases++;
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0)
    begin
      $display("the cases file holds no usable case");
      $display("sim failed");
      $fatal(1, "empty cases file");
    end
  endtask

  task automatic expect_idle_outputs();
    check_value(dma1_fromhost_valid, 1'b0, "dma1_fromhost_valid");
    check_value(dma1_fromhost_data, '0, "dma1_fromhost_data");
    check_value(dma1_fromhost_ctrl, '0, "dma1_fromhost_ctrl");
    check_value(dma1_tohost_almost_full, 1'b0, "dma1_tohost_almost_full");
    check_value(s1_axis_fromhost_tready, 1'b0, "s1_axis_fromhost_tready");
    check_value(dma0_fromhost_valid, 1'b0, "dma0_fromhost_valid");
    check_value(dma0_fromhost_data, '0, "dma0_fromhost_data");
    check_value(dma0_fromhost_ctrl, '0, "dma0_fromhost_ctrl");
    check_value(dma0_tohost_almost_full, 1'b0, "dma0_tohost_almost_full");
    check_value(m0_axis_tohost_tvalid, 1'b0, "m0_axis_tohost_tvalid");
    check_value(m0_axis_tohost_tlast, 1'b0, "m0_axis_tohost_tlast");
    check_value(m0_axis_tohost_tdata, '0, "m0_axis_tohost_tdata");
  endtask

  task automatic push_down_req(input logic [3:0] tag, input logic [15:0] len);
    logic [63:0] word0;
    word0 = random_word();
    word0[dma_bridge_pkg::req_tag_lsb +: 4] = tag;
    word0[dma_bridge_pkg::req_len_lsb +: 16] = len;
    @(negedge clk);
    dma1_tohost_valid = 1'b1;
    dma1_tohost_ctrl  = c_req;
    dma1_tohost_data  = word0;
    @(negedge clk);
    dma1_tohost_ctrl  = c_req | c_hi;          // high word pushes the request
    dma1_tohost_data  = random_word();
    @(negedge clk);
    dma1_tohost_valid = 1'b0;
    dma1_tohost_ctrl  = '0;
  endtask

  // both ack words, checked on every cycle they are offered
  task automatic collect_acks(input bit up, input logic [3:0] tag, input logic [15:0] len,
                              input int stall);
    logic [63:0] exp_data [2];
    logic [7:0]  exp_ctrl [2];
    logic        acc;
    int          k;
    string       pfx;
    exp_data[0] = 64'(tag) << dma_bridge_pkg::ack_tag_lsb;
    exp_data[1] = 64'(len);
    exp_ctrl[0] = c_first | (up ? c_req : 8'h00);
    exp_ctrl[1] = c_second | (up ? c_req : 8'h00);
    if (up)
      pfx = "dma0_fromhost";
    else
      pfx = "dma1_fromhost";
    k = 0;
    while (k < 2)
    begin
      @(negedge clk);
      acc = pick_ready(stall);
      if (up)
        dma0_fromhost_accept = acc;
      else
        dma1_fromhost_accept = acc;
      #2;
      if (up ? dma0_fromhost_valid : dma1_fromhost_valid)
      begin
        check_value(up ? dma0_fromhost_data : dma1_fromhost_data, exp_data[k],
                    {pfx, "_data"});
        check_value(up ? dma0_fromhost_ctrl : dma1_fromhost_ctrl, exp_ctrl[k],
                    {pfx, "_ctrl"});
        if (acc)
          k++;
      end
    end
  endtask

  task automatic send_down_data(input int beats, input logic [7:0] keep, input int stall);
    logic [63:0] data;
    logic [7:0]  exp_ctrl;
    logic        last;
    logic        acc;
    int          b;
    for (b = 0; b < beats; b++)
    begin
      data = random_word();
      last = (b == beats - 1);
      if (!last)
        exp_ctrl = c_lo | c_hi;
      else if (keep <= 8'h0f)
        exp_ctrl = c_req | c_lo;               // low half end code
      else
        exp_ctrl = c_req | c_lo | c_hi;
      acc = 1'b0;
      while (!acc)
      begin
        @(negedge clk);
        acc = pick_ready(stall);
        s1_axis_fromhost_tvalid = 1'b1;
        s1_axis_fromhost_tdata  = data;
        s1_axis_fromhost_tkeep  = last ? keep : 8'hff;
        s1_axis_fromhost_tlast  = last;
        dma1_fromhost_accept    = acc;
        #2;
        check_value(s1_axis_fromhost_tready, acc, "s1_axis_fromhost_tready");
        check_value(dma1_fromhost_valid, 1'b1, "dma1_fromhost_valid");
        check_value(dma1_fromhost_data, data, "dma1_fromhost_data");
        check_value(dma1_fromhost_ctrl, exp_ctrl, "dma1_fromhost_ctrl");
      end
    end
    @(negedge clk);
    s1_axis_fromhost_tvalid = 1'b0;
    s1_axis_fromhost_tlast  = 1'b0;
    dma1_fromhost_accept    = 1'b0;
  endtask

  task automatic up_transfer(input logic [3:0] tag, input logic [15:0] len,
                             input logic [15:0] bytes, input int beats,
                             input logic [7:0] keep, input int stall);
    logic [63:0] word0;
    logic [63:0] data;
    logic        last;
    logic        rdy;
    int          b;
    word0 = random_word();
    word0[dma_bridge_pkg::req_tag_lsb +: 4] = tag;
    word0[dma_bridge_pkg::req_len_lsb +: 16] = len;
    data = random_word();
    data[dma_bridge_pkg::req_bytes_lsb +: 16] = bytes;
    @(negedge clk);
    dma0_tohost_valid     = 1'b1;
    dma0_tohost_ctrl      = c_req;
    dma0_tohost_data      = word0;
    dma0_fromhost_accept  = 1'b0;
    m0_axis_tohost_tready = 1'b0;             // request words ignore tready
    #2;
    check_value(m0_axis_tohost_tvalid, 1'b0, "m0_axis_tohost_tvalid");
    check_value(dma0_tohost_almost_full, 1'b0, "dma0_tohost_almost_full");
    check_value(dma0_fromhost_valid, 1'b0, "dma0_fromhost_valid");
    @(negedge clk);
    dma0_tohost_data = data;
    for (b = 0; b < beats; b++)
    begin
      data = random_word();
      last = (b == beats - 1);
      rdy  = 1'b0;
      while (!rdy)
      begin
        @(negedge clk);
        rdy = pick_ready(stall);
        dma0_tohost_valid     = 1'b1;
        dma0_tohost_ctrl      = last ? (c_lo | c_hi) : c_lo;
        dma0_tohost_data      = data;
        m0_axis_tohost_tready = rdy;
        #2;
        check_value(m0_axis_tohost_tvalid, 1'b1, "m0_axis_tohost_tvalid");
        check_value(m0_axis_tohost_tdata, data, "m0_axis_tohost_tdata");
        check_value(m0_axis_tohost_tlast, last, "m0_axis_tohost_tlast");
        check_value(m0_axis_tohost_tkeep, last ? keep : 8'hff, "m0_axis_tohost_tkeep");
        check_value(dma0_tohost_almost_full, !rdy, "dma0_tohost_almost_full");
      end
    end
    @(negedge clk);
    dma0_tohost_valid     = 1'b0;
    dma0_tohost_ctrl      = '0;
    m0_axis_tohost_tready = 1'b0;
    #2;
    check_value(dma0_fromhost_valid, 1'b1, "dma0_fromhost_valid");   // one cycle after last
    collect_acks(1'b1, tag, len, stall);
  endtask

  // ************************************************************************
  // request queueing with accept held low
  // ************************************************************************
  task automatic queue_requests();
    int i;
    dma1_fromhost_accept = 1'b0;
    for (i = 0; i < req_depth; i++)
    begin
      push_down_req(4'(i), 16'(8 * (i + 1)));
      if (i >= req_depth - 2)
      begin
        @(negedge clk);
        #2;
        // the first request leaves at once, so i entries stay queued
        check_value(dma1_tohost_almost_full, (i >= req_depth - 1), "dma1_tohost_almost_full");
      end
    end
    for (i = 0; i < req_depth; i++)
    begin
      collect_acks(1'b0, 4'(i), 16'(8 * (i + 1)), 1);
      send_down_data(1, (i % 2) ? 8'h0f : 8'hff, 1);
    end
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: the run went past %0d cycles", limit);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // stop at the first protocol assertion failure
  always @(posedge clk)
  begin
    if (DUT.u_chk.assert_fails != 0)
    begin
      $display("a protocol assertion failed before %0t ns", $time);
      $display("sim failed");
      $fatal(1, "assertion failure");
    end
  end

  initial
  begin
    seed = 35;
    rst_n = 1'b0;
    dma1_tohost_data = '0;
    dma1_tohost_ctrl = '0;
    dma1_tohost_valid = 1'b0;
    dma1_fromhost_accept = 1'b0;
    s1_axis_fromhost_tvalid = 1'b0;
    s1_axis_fromhost_tdata = '0;
    s1_axis_fromhost_tkeep = '0;
    s1_axis_fromhost_tlast = 1'b0;
    dma0_tohost_data = '0;
    dma0_tohost_ctrl = '0;
    dma0_tohost_valid = 1'b0;
    dma0_fromhost_accept = 1'b0;
    m0_axis_tohost_tready = 1'b0;
    read_cases();
    limit = 200 + req_depth * (4 + 40);         // queueing test, one beat each
    for (int i = 0; i < n_cases; i++)
      limit += 4 * case_beats[i] + 40;
    repeat (8) @(negedge clk);
    #2;
    expect_idle_outputs();                      // inside reset
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    #2;
    expect_idle_outputs();
    for (int i = 0; i < n_cases; i++)
    begin
      if (case_chan[i] == "u")
        up_transfer(case_tag[i], case_len[i], case_bytes[i], case_beats[i],
                    case_keep[i], case_stall[i]);
      else
      begin
        push_down_req(case_tag[i], case_len[i]);
        collect_acks(1'b0, case_tag[i], case_len[i], case_stall[i]);
        send_down_data(case_beats[i], case_keep[i], case_stall[i]);
      end
    end
    queue_requests();
    repeat (4) @(negedge clk);
    if (DUT.u_chk.assert_fails == 0)
      $display("sim passed");
    else
    begin
      $display("sim failed");
      $fatal(1, "protocol assertion failed");
    end
    $finish;
  end

endmodule

// File: sim/dma_bridge_cases.txt
# chan tag length bytes beats last_tkeep stall
# chan u = upstream channel 0, d = downstream channel 1; tag length bytes tkeep in hex
d 1 0040 0040 8 ff 0
d 2 0013 0013 3 07 1
d 3 0008 0008 1 ff 1
d 4 002c 002c 6 0f 1
d 5 0021 0021 5 01 0
u 6 0040 0040 8 ff 0
u 7 0013 0013 3 07 1
u 8 0005 0005 1 1f 1
u 9 002e 002e 6 3f 1
u a 0019 0019 4 01 0
u b 0010 0010 2 ff 1
d c 007f 007f 16 7f 1
u d 007f 007f 16 7f 1
d e 0030 0030 6 ff 1
u f 0001 0001 1 01 1
d 0 0004 0004 1 0f 0

// File: project.f
common/dma_bridge_pkg.sv
hw/dma_ack_gen.sv
hw/downstream/req_fifo.sv
hw/downstream/down_channel.sv
hw/upstream/up_channel.sv
hw/dma_bridge_top.sv
sim/tb_clk_gen.sv
sim/dma_bridge_chk.sv
sim/dma_bridge_tb.sv
